// File: common/recorder_pkg.sv
package recorder_pkg;

	////////////////////
	// Sizes
	////////////////////

	// Memory word address width
	localparam int ADDR_W = 26;
	// Number of message slots
	localparam int TRACK_COUNT = 5;
	// Track number width, 0 means no track
	localparam int TRACK_IDX_W = 3;
	// Volume setting width
	localparam int VOL_W = 3;

	// Words in one slot region
	localparam logic [ADDR_W-1:0] TRACK_SPAN = 26'h333333;
	// Last word of the memory, end of region 5
	localparam logic [ADDR_W-1:0] MAX_RAM_ADDR = {ADDR_W{1'b1}};

	////////////////////
	// Types
	////////////////////

	// Keys in use on the 4x4 pad
	typedef enum logic [3:0] {
		key_none,
		key_0,
		key_1,
		key_2,
		key_3,
		key_4,
		key_5,
		key_6,
		key_a,
		key_b
	} key_code_t;

	// Menu states, order is the APB encoding
	typedef enum logic [2:0] {
		st_init,
		st_menu,
		st_play_menu,
		st_play,
		st_record,
		st_delete_menu,
		st_volume,
		st_full
	} menu_state_t;

	// Opcodes from menu stage to track stage
	typedef enum logic [2:0] {
		cmd_none,
		cmd_record,
		cmd_stop,
		cmd_play,
		cmd_delete,
		cmd_delete_all
	} track_cmd_t;

	////////////////////
	// APB register map
	////////////////////

	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 32;

	localparam logic [APB_ADDR_W-1:0] REG_STATE = 8'h00;
	localparam logic [APB_ADDR_W-1:0] REG_VOLUME = 8'h04;
	// Bit 5 storage full, bits 4..0 valid mask
	localparam logic [APB_ADDR_W-1:0] REG_FLAGS = 8'h08;
	// Five end address words, one per track, 4 bytes apart
	localparam logic [APB_ADDR_W-1:0] REG_TRACK_END_BASE = 8'h0C;

endpackage

// File: design/keypad_decoder.sv
`timescale 1ns/10ps

module keypad_decoder (
	input  logic                    pb_clk,
	input  logic                    RAM_reset,
	input  logic [3:0]              key_row,
	input  logic [3:0]              key_col,
	output recorder_pkg::key_code_t key,
	output logic                    key_event
);

	// Registered pad lines
	logic [3:0] row_q;
	logic [3:0] col_q;
	// Decoded key of the registered lines
	recorder_pkg::key_code_t code;

	// First stage, sample the pad
	always_ff @(posedge pb_clk) begin
		if (RAM_reset) begin
			row_q <= '0;
			col_q <= '0;
		end else begin
			row_q <= key_row;
			col_q <= key_col;
		end
	end

	// Row and column pair to key, lowest row wins
	always_comb begin
		code = recorder_pkg::key_none;
		if (row_q[0]) begin
			if (col_q[0])
				code = recorder_pkg::key_1;
			else if (col_q[1])
				code = recorder_pkg::key_2;
			else if (col_q[2])
				code = recorder_pkg::key_3;
			else if (col_q[3])
				code = recorder_pkg::key_a;
		end else if (row_q[1]) begin
			if (col_q[0])
				code = recorder_pkg::key_4;
			else if (col_q[1])
				code = recorder_pkg::key_5;
			else if (col_q[2])
				code = recorder_pkg::key_6;
			else if (col_q[3])
				code = recorder_pkg::key_b;
		end else if (row_q[3] && col_q[0]) begin
			code = recorder_pkg::key_0;
		end
	end

	// Second stage, one event per new press
	// A held key keeps key at its code, so no repeat
	always_ff @(posedge pb_clk) begin
		if (RAM_reset) begin
			key       <= recorder_pkg::key_none;
			key_event <= 1'b0;
		end else begin
			key       <= code;
			key_event <= (code != recorder_pkg::key_none) && (key == recorder_pkg::key_none);
		end
	end

	// Menu stage relies on a real key with every event
	a_event_has_key: assert property (@(posedge pb_clk) disable iff (RAM_reset)
		key_event |-> key != recorder_pkg::key_none);

endmodule

// File: menu/menu_fsm.sv
`timescale 1ns/10ps

module menu_fsm (
	input  logic                                 pb_clk,
	input  logic                                 RAM_reset,
	input  recorder_pkg::key_code_t              key,
	input  logic                                 key_event,
	input  logic                                 cmd_done,
	input  logic                                 alloc_fail,
	input  logic [recorder_pkg::TRACK_COUNT-1:0] track_valid,
	output recorder_pkg::menu_state_t            state,
	output recorder_pkg::track_cmd_t             cmd,
	output logic [recorder_pkg::TRACK_IDX_W-1:0] cmd_track,
	output logic [recorder_pkg::VOL_W-1:0]       volume,
	output logic                                 storage_full
);

	// Track picked by a digit key, 0 for any other key
	logic [recorder_pkg::TRACK_IDX_W-1:0] sel;

	// Keys 1 to 5 name tracks 1 to 5
	function automatic logic [recorder_pkg::TRACK_IDX_W-1:0] key_track(
		recorder_pkg::key_code_t k
	);
		logic [recorder_pkg::TRACK_IDX_W-1:0] idx;
		case (k)
			recorder_pkg::key_1: idx = 3'd1;
			recorder_pkg::key_2: idx = 3'd2;
			recorder_pkg::key_3: idx = 3'd3;
			recorder_pkg::key_4: idx = 3'd4;
			recorder_pkg::key_5: idx = 3'd5;
			default:             idx = 3'd0;
		endcase
		return idx;
	endfunction

	assign sel = key_track(key);

	////////////////////
	// Menu FSM
	////////////////////

	always_ff @(posedge pb_clk) begin
		if (RAM_reset) begin
			state        <= recorder_pkg::st_init;
			cmd          <= recorder_pkg::cmd_none;
			cmd_track    <= '0;
			volume       <= '0;
			storage_full <= 1'b0;
		end else begin
			// Commands are single cycle pulses
			cmd <= recorder_pkg::cmd_none;
			case (state)
				recorder_pkg::st_init: begin
					state <= recorder_pkg::st_menu;
				end
				// Main menu, wait for a selection
				recorder_pkg::st_menu: begin
					if (key_event) begin
						case (key)
							recorder_pkg::key_1: state <= recorder_pkg::st_play_menu;
							recorder_pkg::key_2: begin
								cmd   <= recorder_pkg::cmd_record;
								state <= recorder_pkg::st_record;
							end
							recorder_pkg::key_3: state <= recorder_pkg::st_delete_menu;
							// Delete all runs at once, no answer awaited
							recorder_pkg::key_4: begin
								cmd          <= recorder_pkg::cmd_delete_all;
								storage_full <= 1'b0;
							end
							recorder_pkg::key_5: state <= recorder_pkg::st_volume;
							default: ;
						endcase
					end
				end
				// Pick a track to play
				recorder_pkg::st_play_menu: begin
					if (key_event) begin
						if (key == recorder_pkg::key_0) begin
							state <= recorder_pkg::st_menu;
						end else if (sel != '0) begin
							// Empty track goes straight back, no command
							if (track_valid[sel - 1'b1]) begin
								cmd       <= recorder_pkg::cmd_play;
								cmd_track <= sel;
								state     <= recorder_pkg::st_play;
							end else begin
								state <= recorder_pkg::st_menu;
							end
						end
					end
				end
				// Playback runs until the sequencer reports the end
				recorder_pkg::st_play: begin
					if (cmd_done)
						state <= recorder_pkg::st_menu;
				end
				// Recording, no free slot or done or stop key
				recorder_pkg::st_record: begin
					if (alloc_fail) begin
						storage_full <= 1'b1;
						state        <= recorder_pkg::st_full;
					end else if (cmd_done) begin
						state <= recorder_pkg::st_menu;
					end else if (key_event && key == recorder_pkg::key_0) begin
						cmd <= recorder_pkg::cmd_stop;
					end
				end
				// Storage full notice lasts one cycle
				recorder_pkg::st_full: begin
					state <= recorder_pkg::st_menu;
				end
				// Pick a track to delete
				recorder_pkg::st_delete_menu: begin
					if (key_event) begin
						if (key == recorder_pkg::key_0) begin
							state <= recorder_pkg::st_menu;
						end else if (sel != '0) begin
							cmd          <= recorder_pkg::cmd_delete;
							cmd_track    <= sel;
							storage_full <= 1'b0;
							state        <= recorder_pkg::st_menu;
						end
					end
				end
				// Volume, A up and B down, saturating
				recorder_pkg::st_volume: begin
					if (key_event) begin
						if (key == recorder_pkg::key_a && volume != '1)
							volume <= volume + 1'b1;
						else if (key == recorder_pkg::key_b && volume != '0)
							volume <= volume - 1'b1;
						else if (key == recorder_pkg::key_0)
							state <= recorder_pkg::st_menu;
					end
				end
				default: begin
					state <= recorder_pkg::st_menu;
				end
			endcase
		end
	end

	// Sequencer sees one cycle per command
	a_cmd_pulse: assert property (@(posedge pb_clk) disable iff (RAM_reset)
		cmd != recorder_pkg::cmd_none |=> cmd == recorder_pkg::cmd_none);

endmodule

// File: track/track_sequencer.sv
`timescale 1ns/10ps

module track_sequencer (
	input  logic                                  pb_clk,
	input  logic                                  RAM_reset,
	input  recorder_pkg::track_cmd_t              cmd,
	input  logic [recorder_pkg::TRACK_IDX_W-1:0]  cmd_track,
	input  logic                                  sample_tick,
	output logic                                  cmd_done,
	output logic                                  alloc_fail,
	output logic [recorder_pkg::TRACK_COUNT-1:0]  track_valid,
	output logic [recorder_pkg::TRACK_COUNT-1:0][recorder_pkg::ADDR_W-1:0] track_end,
	output logic [recorder_pkg::ADDR_W-1:0]       mem_addr,
	output logic                                  mem_write,
	output logic                                  mem_read,
	output logic                                  recording,
	output logic                                  playing
);

	// Current word and the last word of the running transfer
	logic [recorder_pkg::ADDR_W-1:0] addr;
	logic [recorder_pkg::ADDR_W-1:0] last;
	// Slot being recorded, 0 based
	logic [recorder_pkg::TRACK_IDX_W-1:0] cur_slot;
	// Lowest free slot
	logic [recorder_pkg::TRACK_IDX_W-1:0] free_slot;
	logic                                 free_found;
	// Slot named by the command, 0 based
	logic [recorder_pkg::TRACK_IDX_W-1:0] trk_slot;

	// First word of a slot region
	function automatic logic [recorder_pkg::ADDR_W-1:0] region_start(
		logic [recorder_pkg::TRACK_IDX_W-1:0] slot
	);
		logic [recorder_pkg::ADDR_W-1:0] start;
		start = '0;
		for (int i = 0; i < recorder_pkg::TRACK_COUNT; i++) begin
			if (i < slot)
				start = start + recorder_pkg::TRACK_SPAN;
		end
		return start;
	endfunction

	// Last word of a slot region, top slot runs to the end of memory
	function automatic logic [recorder_pkg::ADDR_W-1:0] region_last(
		logic [recorder_pkg::TRACK_IDX_W-1:0] slot
	);
		if (slot == recorder_pkg::TRACK_COUNT - 1)
			return recorder_pkg::MAX_RAM_ADDR;
		return region_start(slot) + recorder_pkg::TRACK_SPAN - 1'b1;
	endfunction

	// Scan from the top so the lowest free slot is left
	always_comb begin
		free_found = 1'b0;
		free_slot  = '0;
		for (int i = recorder_pkg::TRACK_COUNT - 1; i >= 0; i--) begin
			if (!track_valid[i]) begin
				free_found = 1'b1;
				free_slot  = recorder_pkg::TRACK_IDX_W'(i);
			end
		end
	end

	assign trk_slot = cmd_track - 1'b1;

	////////////////////
	// Sequencing
	////////////////////

	always_ff @(posedge pb_clk) begin
		if (RAM_reset) begin
			recording   <= 1'b0;
			playing     <= 1'b0;
			cmd_done    <= 1'b0;
			alloc_fail  <= 1'b0;
			track_valid <= '0;
			track_end   <= '0;
			addr        <= '0;
			last        <= '0;
			cur_slot    <= '0;
		end else begin
			cmd_done   <= 1'b0;
			alloc_fail <= 1'b0;
			if (recording) begin
				// One word per sample, end address follows the last write
				if (sample_tick) begin
					track_end[cur_slot] <= addr;
					if (addr == last) begin
						recording <= 1'b0;
						cmd_done  <= 1'b1;
					end else begin
						addr <= addr + 1'b1;
					end
				end
				if (cmd == recorder_pkg::cmd_stop) begin
					recording <= 1'b0;
					cmd_done  <= 1'b1;
				end
			end else if (playing) begin
				if (sample_tick) begin
					if (addr == last) begin
						playing  <= 1'b0;
						cmd_done <= 1'b1;
					end else begin
						addr <= addr + 1'b1;
					end
				end
				if (cmd == recorder_pkg::cmd_stop) begin
					playing  <= 1'b0;
					cmd_done <= 1'b1;
				end
			end else begin
				case (cmd)
					// Claim the lowest free slot or report full
					recorder_pkg::cmd_record: begin
						if (free_found) begin
							track_valid[free_slot] <= 1'b1;
							track_end[free_slot]   <= region_start(free_slot);
							cur_slot               <= free_slot;
							addr                   <= region_start(free_slot);
							last                   <= region_last(free_slot);
							recording              <= 1'b1;
						end else begin
							alloc_fail <= 1'b1;
						end
					end
					// Menu has already checked the slot holds a message
					recorder_pkg::cmd_play: begin
						addr    <= region_start(trk_slot);
						last    <= track_end[trk_slot];
						playing <= 1'b1;
					end
					recorder_pkg::cmd_delete:     track_valid[trk_slot] <= 1'b0;
					recorder_pkg::cmd_delete_all: track_valid <= '0;
					default: ;
				endcase
			end
		end
	end

	// Strobes go out in the tick cycle
	assign mem_addr  = addr;
	assign mem_write = recording & sample_tick;
	assign mem_read  = playing & sample_tick;

	// Memory port carries one direction at a time
	a_one_direction: assert property (@(posedge pb_clk) disable iff (RAM_reset)
		!(recording && playing));

endmodule

// File: design/status_apb.sv
`timescale 1ns/10ps

module status_apb (
	input  logic                                  pb_clk,
	input  logic                                  RAM_reset,
	input  logic                                  psel,
	input  logic                                  penable,
	input  logic                                  pwrite,
	input  logic [recorder_pkg::APB_ADDR_W-1:0]   paddr,
	input  logic [recorder_pkg::APB_DATA_W-1:0]   pwdata,
	input  recorder_pkg::menu_state_t             state,
	input  logic [recorder_pkg::VOL_W-1:0]        volume,
	input  logic                                  storage_full,
	input  logic [recorder_pkg::TRACK_COUNT-1:0]  track_valid,
	input  logic [recorder_pkg::TRACK_COUNT-1:0][recorder_pkg::ADDR_W-1:0] track_end,
	output logic [recorder_pkg::APB_DATA_W-1:0]   prdata,
	output logic                                  pready,
	output logic                                  pslverr
);

	// Selected register and map hit
	logic [recorder_pkg::APB_DATA_W-1:0] rd_data;
	logic                                rd_hit;

	// Register decode, fields zero extended
	always_comb begin
		rd_data = '0;
		rd_hit  = 1'b1;
		case (paddr)
			recorder_pkg::REG_STATE:  rd_data = recorder_pkg::APB_DATA_W'(state);
			recorder_pkg::REG_VOLUME: rd_data = recorder_pkg::APB_DATA_W'(volume);
			recorder_pkg::REG_FLAGS:
				rd_data = recorder_pkg::APB_DATA_W'({storage_full, track_valid});
			default: begin
				// Track end words, one per slot
				rd_hit = 1'b0;
				for (int i = 0; i < recorder_pkg::TRACK_COUNT; i++) begin
					if (paddr == recorder_pkg::REG_TRACK_END_BASE + 4 * i) begin
						rd_hit  = 1'b1;
						rd_data = recorder_pkg::APB_DATA_W'(track_end[i]);
					end
				end
			end
		endcase
	end

	// Captured in setup, stable through the access phase
	// Writes and unmapped offsets only raise the error
	always_ff @(posedge pb_clk) begin
		if (RAM_reset) begin
			prdata  <= '0;
			pslverr <= 1'b0;
		end else if (psel && !penable) begin
			prdata  <= pwrite ? '0 : rd_data;
			pslverr <= pwrite || !rd_hit;
		end else begin
			pslverr <= 1'b0;
		end
	end

	// No wait states
	assign pready = 1'b1;

	// Access phase only after a setup cycle
	a_apb_setup: assert property (@(posedge pb_clk) disable iff (RAM_reset)
		penable |-> $past(psel && !penable));

endmodule

// File: design/voice_recorder_top.sv
`timescale 1ns/10ps

module voice_recorder_top (
	input  logic                                pb_clk,
	input  logic                                RAM_reset,
	input  logic [3:0]                          key_row,
	input  logic [3:0]                          key_col,
	input  logic                                sample_tick,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [recorder_pkg::APB_ADDR_W-1:0] paddr,
	input  logic [recorder_pkg::APB_DATA_W-1:0] pwdata,
	output logic [recorder_pkg::APB_DATA_W-1:0] prdata,
	output logic                                pready,
	output logic                                pslverr,
	output logic [recorder_pkg::ADDR_W-1:0]     mem_addr,
	output logic                                mem_write,
	output logic                                mem_read,
	output logic [recorder_pkg::VOL_W-1:0]      volume,
	output logic                                playing,
	output logic                                recording
);

	////////////////////
	// Stage links
	////////////////////

	// Key decode to menu
	recorder_pkg::key_code_t key;
	logic                    key_event;
	// Menu to track stage
	recorder_pkg::track_cmd_t             cmd;
	logic [recorder_pkg::TRACK_IDX_W-1:0] cmd_track;
	// Track stage answers
	logic cmd_done;
	logic alloc_fail;
	// Status
	recorder_pkg::menu_state_t                                      state;
	logic                                                           storage_full;
	logic [recorder_pkg::TRACK_COUNT-1:0]                           track_valid;
	logic [recorder_pkg::TRACK_COUNT-1:0][recorder_pkg::ADDR_W-1:0] track_end;

	keypad_decoder i_keypad_decoder (
		.pb_clk    (pb_clk),
		.RAM_reset (RAM_reset),
		.key_row   (key_row),
		.key_col   (key_col),
		.key       (key),
		.key_event (key_event)
	);

	menu_fsm i_menu_fsm (
		.pb_clk       (pb_clk),
		.RAM_reset    (RAM_reset),
		.key          (key),
		.key_event    (key_event),
		.cmd_done     (cmd_done),
		.alloc_fail   (alloc_fail),
		.track_valid  (track_valid),
		.state        (state),
		.cmd          (cmd),
		.cmd_track    (cmd_track),
		.volume       (volume),
		.storage_full (storage_full)
	);

	track_sequencer i_track_sequencer (
		.pb_clk      (pb_clk),
		.RAM_reset   (RAM_reset),
		.cmd         (cmd),
		.cmd_track   (cmd_track),
		.sample_tick (sample_tick),
		.cmd_done    (cmd_done),
		.alloc_fail  (alloc_fail),
		.track_valid (track_valid),
		.track_end   (track_end),
		.mem_addr    (mem_addr),
		.mem_write   (mem_write),
		.mem_read    (mem_read),
		.recording   (recording),
		.playing     (playing)
	);

	// Host status port
	status_apb i_status_apb (
		.pb_clk       (pb_clk),
		.RAM_reset    (RAM_reset),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.state        (state),
		.volume       (volume),
		.storage_full (storage_full),
		.track_valid  (track_valid),
		.track_end    (track_end),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr)
	);

endmodule

// File: tests/voice_recorder_tb.sv
`timescale 1ns/10ps

module voice_recorder_tb;

	// DUT inputs
	logic                                pb_clk;
	logic                                RAM_reset;
	logic [3:0]                          key_row;
	logic [3:0]                          key_col;
	logic                                sample_tick;
	logic                                psel;
	logic                                penable;
	logic                                pwrite;
	logic [recorder_pkg::APB_ADDR_W-1:0] paddr;
	logic [recorder_pkg::APB_DATA_W-1:0] pwdata;
	// DUT outputs
	logic [recorder_pkg::APB_DATA_W-1:0] prdata;
	logic                                pready;
	logic                                pslverr;
	logic [recorder_pkg::ADDR_W-1:0]     mem_addr;
	logic                                mem_write;
	logic                                mem_read;
	logic [recorder_pkg::VOL_W-1:0]      volume;
	logic                                playing;
	logic                                recording;

	// Steps read from the stimulus file
	logic [8*8-1:0]  step_kind[$];
	logic [31:0]     step_a[$];
	logic [31:0]     step_b[$];
	logic [31:0]     step_c[$];
	logic [8*32-1:0] step_name[$];
	// Watchdog limit in cycles
	longint budget;
	logic   budget_ready = 1'b0;

	voice_recorder_top i_dut (.*);

	// 4 ns clock
	initial begin
		pb_clk = 1'b0;
		forever #2 pb_clk = ~pb_clk;
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_state(input logic [8*32-1:0] name,
			input recorder_pkg::menu_state_t exp, input recorder_pkg::menu_state_t act);
		if (act !== exp) begin
			$display("Fail %0s: expected state %0d actual state %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_word(input logic [8*32-1:0] name,
			input logic [recorder_pkg::APB_DATA_W-1:0] exp,
			input logic [recorder_pkg::APB_DATA_W-1:0] act);
		if (act !== exp) begin
			$display("Fail %0s: expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	// Press and release one key, long enough for the menu to react
	task automatic press_key(input logic [31:0] row, input logic [31:0] col);
		@(posedge pb_clk);
		key_row <= 4'b1 << row[1:0];
		key_col <= 4'b1 << col[1:0];
		repeat (3) @(posedge pb_clk);
		key_row <= '0;
		key_col <= '0;
		repeat (4) @(posedge pb_clk);
	endtask

	// One APB transfer, response sampled mid access phase
	task automatic apb_access(input logic wr, input logic [31:0] off,
			output logic [31:0] data, output logic err);
		@(posedge pb_clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= off[recorder_pkg::APB_ADDR_W-1:0];
		pwdata  <= wr ? $urandom : '0;
		@(posedge pb_clk);
		penable <= 1'b1;
		@(negedge pb_clk);
		data = prdata;
		err  = pslverr;
		// No wait states, access phase completes at once
		if (pready !== 1'b1) begin
			$display("PREADY was low in the access phase at offset %0h", off);
			abort_run();
		end
		@(posedge pb_clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	// Sample ticks with random gaps, each must strobe the next word
	task automatic run_ticks(input logic rd_mode, input logic [31:0] n,
			input logic [31:0] first, input logic [8*32-1:0] name);
		int gap;
		for (int i = 0; i < n; i++) begin
			gap = $urandom % 4;
			repeat (gap) begin
				@(posedge pb_clk);
				sample_tick <= 1'b0;
			end
			@(posedge pb_clk);
			sample_tick <= 1'b1;
			@(negedge pb_clk);
			check_word(name, 32'd1, rd_mode ? mem_read : mem_write);
			check_word(name, 32'd0, rd_mode ? mem_write : mem_read);
			check_word(name, first + i, mem_addr);
			// Only the running direction is busy
			check_word(name, rd_mode ? 32'd0 : 32'd1, recording);
			check_word(name, rd_mode ? 32'd1 : 32'd0, playing);
		end
		@(posedge pb_clk);
		sample_tick <= 1'b0;
		// Playback ends by itself after the stored end word
		if (rd_mode) begin
			@(negedge pb_clk);
			if (playing !== 1'b0) begin
				$display("Playback of %0s did not stop after its last word", name);
				abort_run();
			end
		end
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		logic [31:0]     data;
		logic            err;
		int              fd;
		int              n;
		logic [8*128-1:0] line;
		logic [8*8-1:0]  kind;
		logic [31:0]     a;
		logic [31:0]     b;
		logic [31:0]     c;
		logic [8*32-1:0] name;
		recorder_pkg::menu_state_t exp_st;

		RAM_reset   = 1'b1;
		key_row     = '0;
		key_col     = '0;
		sample_tick = 1'b0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		void'($urandom(87408));

		fd = $fopen("tests/voice_recorder_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			abort_run();
		end
		// Comment lines start with # and are skipped
		while ($fgets(line, fd) != 0) begin
			n = $sscanf(line, "%s %h %h %h %s", kind, a, b, c, name);
			if (n >= 1 && kind != "#") begin
				if (n != 5) begin
					$display("Malformed line in the stimulus file");
					abort_run();
				end
				step_kind.push_back(kind);
				step_a.push_back(a);
				step_b.push_back(b);
				step_c.push_back(c);
				step_name.push_back(name);
			end
		end
		$fclose(fd);

		// Reset plus margin, then the worst case of each step
		budget = 120;
		for (int s = 0; s < step_kind.size(); s++) begin
			case (step_kind[s])
				"key":        budget += 8 * step_c[s];
				"rec", "play": budget += 4 * step_a[s] + 10;
				default:      budget += 4;
			endcase
		end
		budget_ready = 1'b1;

		repeat (10) @(posedge pb_clk);
		RAM_reset <= 1'b0;

		for (int s = 0; s < step_kind.size(); s++) begin
			case (step_kind[s])
				"key": begin
					repeat (step_c[s]) press_key(step_a[s], step_b[s]);
				end
				"rec":  run_ticks(1'b0, step_a[s], step_b[s], step_name[s]);
				"play": run_ticks(1'b1, step_a[s], step_b[s], step_name[s]);
				"rd": begin
					apb_access(1'b0, step_a[s], data, err);
					check_word(step_name[s], 32'd0, err);
					check_word(step_name[s], step_b[s], data);
					// Volume pins carry the same value as the register
					if (step_a[s] == recorder_pkg::REG_VOLUME) begin
						@(negedge pb_clk);
						check_word(step_name[s], step_b[s], volume);
					end
				end
				"st": begin
					exp_st = recorder_pkg::menu_state_t'(step_b[s][2:0]);
					apb_access(1'b0, recorder_pkg::REG_STATE, data, err);
					check_word(step_name[s], 32'd0, err);
					check_state(step_name[s], exp_st,
						recorder_pkg::menu_state_t'(data[2:0]));
					// Transfer flags follow the menu state
					@(negedge pb_clk);
					check_word(step_name[s], 32'(exp_st == recorder_pkg::st_record),
						recording);
					check_word(step_name[s], 32'(exp_st == recorder_pkg::st_play),
						playing);
				end
				// Rejected accesses, write or unmapped read
				"wr", "bad": begin
					apb_access(step_kind[s] == "wr", step_a[s], data, err);
					check_word(step_name[s], 32'd1, err);
				end
				default: begin
					$display("Unknown step kind in the stimulus file");
					abort_run();
				end
			endcase
		end

		$display("Simulation finished: PASS");
		$finish;
	end

	// Watchdog
	initial begin
		wait (budget_ready === 1'b1);
		#(budget * 4);
		$display("Run timed out after %0d cycles before all steps finished", budget);
		abort_run();
	end

endmodule

// File: tests/voice_recorder_stimulus.txt
# kind a b c name, hex; key: row col presses; rec/play: ticks first_addr; rd: offset expected
# st: expected menu state in b; wr/bad: offset in a that must give PSLVERR
st   0  1      0 reset_to_menu
key  0  1      1 rec1_start
rec  7  0      0 rec1_words
key  3  0      1 rec1_stop
st   0  1      0 rec1_back_to_menu
rd   8  1      0 rec1_flags
rd   c  6      0 rec1_end
key  0  0      2 play1_select
play 7  0      0 play1_words
st   0  1      0 play1_back_to_menu
key  0  0      1 play_empty_menu
key  0  2      1 play_empty_pick
st   0  1      0 play_empty_state
key  0  1      1 rec2_start
rec  3  333333 0 rec2_words
key  3  0      1 rec2_stop
rd   8  3      0 rec2_flags
rd   10 333335 0 rec2_end
key  0  2      1 del1_menu
key  0  0      1 del1_pick
rd   8  2      0 del1_flags
key  0  1      1 reuse_start
rec  2  0      0 reuse_words
key  3  0      1 reuse_stop
rd   8  3      0 reuse_flags
rd   c  1      0 reuse_end
key  0  1      1 rec3_start
rec  1  666666 0 rec3_words
key  3  0      1 rec3_stop
key  0  1      1 rec4_start
rec  1  999999 0 rec4_words
key  3  0      1 rec4_stop
key  0  1      1 rec5_start
rec  2  cccccc 0 rec5_words
key  3  0      1 rec5_stop
rd   8  1f     0 all_slots_used
rd   14 666666 0 rec3_end
rd   1c cccccd 0 rec5_end
key  0  1      1 rec_when_full
st   0  1      0 full_back_to_menu
rd   8  3f     0 full_flag_set
key  1  0      1 delete_all
rd   8  0      0 delete_all_flags
key  1  1      1 volume_menu
key  0  3      9 volume_up
st   0  6      0 volume_state
rd   4  7      0 volume_max
key  1  3      a volume_down
rd   4  0      0 volume_min
key  3  0      1 volume_exit
st   0  1      0 volume_back_to_menu
wr   0  0      0 write_rejected
bad  20 0      0 offset_32_rejected

// File: voice_recorder_top.f
common/recorder_pkg.sv
design/keypad_decoder.sv
menu/menu_fsm.sv
track/track_sequencer.sv
design/status_apb.sv
design/voice_recorder_top.sv
tests/voice_recorder_tb.sv

// File: Bender.yml
package:
  name: voice_recorder

sources:
  - common/recorder_pkg.sv
  - design/keypad_decoder.sv
  - menu/menu_fsm.sv
  - track/track_sequencer.sv
  - design/status_apb.sv
  - design/voice_recorder_top.sv
  - target: test
    files:
      - tests/voice_recorder_tb.sv
